// File: Makefile
# Verilator build and run of the analog data path testbench
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_analog_top -f compile.f -Mdir obj_dir

run: compile
	./obj_dir/Vtb_analog_top | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
verilog/sys_bus_pkg.sv
verilog/analog_pkg.sv
verilog/sys_bus_decoder.sv
verilog/hk_regs.sv
verilog/ctrl_regs.sv
verilog/adc_frontend.sv
verilog/feedback_mixer.sv
verilog/analog_top.sv
dv/tb_analog_top.sv

// File: dv/analog_vectors.txt
# T test | W addr data | R addr rdata err | L led
# S raw0 raw1 dac0 dac1 (dac 3 cycles later) | D dac0 dac1 (now), all hex
T 1
# Reset state and identification
D 1fff 1fff
L 00
R 0000 414e0001 0
R 0004 00000000 0
R 1000 00000000 0
R 1004 00000000 0
R 1010 00000000 0
R 1014 00000000 0

T 2
# Register access, sign extension and error answers
W 1000 abcd3000
R 1000 fffff000 0
W 1004 00018000
R 1004 ffff8000 0
W 1010 00000123
R 1010 00000123 0
W 1014 00007fff
R 1014 00007fff 0
W 0008 000000a5
R 0008 000000a5 0
L a5
R 000c 00000000 1
R 1008 00000000 1
R 1020 00000000 1
R 2000 00000000 1
R f004 00000000 1

T 3
# Unity gain and zero level, DAC code equals raw[15:2]
W 1004 00001000
W 1014 00001000
W 1000 00000000
W 1010 00000000
S 7ffc 8000 1fff 2000
S 0000 fffc 0000 3fff
S 1237 c4d9 048d 3136
S 5a5b 2003 1696 0800

// File: dv/tb_analog_top.sv
`timescale 1ns/100ps

module tb_analog_top;

  localparam int ACK_TIMEOUT = 20;     // Cycles allowed for ack
  localparam int STREAM_LEN  = 32;     // Checked samples per random round
  localparam int FILL        = 3;      // ADC to DAC latency
  localparam int SMP_MAX     = 8191;
  localparam int SMP_MIN     = -8192;

  logic                  adc_clk = 1'b0;
  logic                  rst_n;
  sys_bus_pkg::sys_req_t sys_req;
  sys_bus_pkg::sys_rsp_t sys_rsp;
  logic [analog_pkg::N_CH-1:0][analog_pkg::ADC_RAW_W-1:0] adc_dat;
  logic [analog_pkg::N_CH-1:0][analog_pkg::SMP_W-1:0]     dac_dat;
  logic [7:0]            led;

  logic [31:0] lfsr       = 32'hb26e129f;
  int          test_errs  = 0;
  int          total_errs = 0;
  int          tests_ok   = 0;
  int          tests_bad  = 0;
  logic        timed_out  = 1'b0;  // Set when the bus hangs and no more requests go out

  analog_top i_analog_top (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n  ),
    .sys_req_i (sys_req),
    .sys_rsp_o (sys_rsp),
    .adc_dat_i (adc_dat),
    .dac_dat_o (dac_dat),
    .led_o     (led    )
  );

  always #50 adc_clk = ~adc_clk;  // 100 ns period

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Neg slope code where 8191 is zero and 0 is full positive
  function automatic int raw_to_smp(input logic [15:0] raw);
    return 8191 - int'(raw[15:2]);  // Reserved LSBs dropped
  endfunction

  function automatic int sat14(input int val);
    if (val > SMP_MAX)
      return SMP_MAX;
    if (val < SMP_MIN)
      return SMP_MIN;
    return val;
  endfunction

  function automatic int mix_smp(input int smp, input int gain, input int level);
    return sat14(((smp * gain) >>> analog_pkg::GAIN_FRAC) + level);  // Floor division
  endfunction

  function automatic logic [13:0] smp_to_code(input int smp);
    return 14'(8191 - smp);  // Inverse of raw_to_smp
  endfunction

  // Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val  = {val[30:0], lfsr[0]};  // One step per bit
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic logic [15:0] ctrl_addr(input int ch, input logic [11:0] ofs);
    return {sys_bus_pkg::REGION_CTRL, 12'(ch) * analog_pkg::CH_STRIDE + ofs};
  endfunction

  ////////////////////////////////////////
  // Reporting and bus access
  ////////////////////////////////////////

  task automatic flag_error(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    test_errs++;
  endtask

  task automatic end_test(input int num);
    if (test_errs == 0)
    begin
      tests_ok++;
      $display("test %0d: ok", num);
    end
    else
    begin
      tests_bad++;
      $display("test %0d: %0d errors", num, test_errs);
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  // One strobe cycle, then wait for ack at falling edges
  task automatic bus_access(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int cnt;
    rdata = '0;
    err   = 1'b0;
    if (timed_out)
      return;
    @(posedge adc_clk);
    sys_req.addr  <= addr;
    sys_req.wdata <= wdata;
    sys_req.wen   <= wr;
    sys_req.ren   <= !wr;
    @(posedge adc_clk);
    sys_req.wen <= 1'b0;
    sys_req.ren <= 1'b0;
    @(negedge adc_clk);
    cnt = 0;
    while (!sys_rsp.ack && cnt < ACK_TIMEOUT)
    begin
      @(negedge adc_clk);
      cnt++;
    end
    if (!sys_rsp.ack)
    begin
      $display("Timeout, ack never came for the request to address %h", addr);
      test_errs++;
      timed_out = 1'b1;
      return;
    end
    rdata = sys_rsp.rdata;
    err   = sys_rsp.err;
  endtask

  task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    bus_access(1'b1, addr, data, rd, err);
    if (err)
      flag_error($sformatf("write to %h answered with err", addr));
  endtask

  task automatic read_check(input logic [15:0] addr, input logic [31:0] exp,
                            input logic exp_err);
    logic [31:0] rd;
    logic        err;
    bus_access(1'b0, addr, '0, rd, err);
    if (timed_out)
      return;
    if (err !== exp_err)
      flag_error($sformatf("read of %h gave err %b, expected %b", addr, err, exp_err));
    else if (!exp_err && rd !== exp)  // Data is don't care on err
      flag_error($sformatf("read of %h gave %h, expected %h", addr, rd, exp));
  endtask

  task automatic check_dac(input logic [analog_pkg::N_CH-1:0][analog_pkg::SMP_W-1:0] exp);
    for (int ch = 0; ch < analog_pkg::N_CH; ch++)
    begin
      if (dac_dat[ch] !== exp[ch])
        flag_error($sformatf("dac ch%0d is %h, expected %h", ch, dac_dat[ch], exp[ch]));
    end
  endtask

  // Drive one raw word per channel, check after the pipeline latency
  task automatic apply_sample(input logic [15:0] raw0, input logic [15:0] raw1,
                              input logic [13:0] exp0, input logic [13:0] exp1);
    @(posedge adc_clk);
    adc_dat[0] <= raw0;
    adc_dat[1] <= raw1;
    repeat (FILL) @(posedge adc_clk);
    @(negedge adc_clk);
    check_dac({exp1, exp0});
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic run_vectors();
    int          fd;
    int          cur;  // Test in progress or 0 before the first T line
    string       line;
    byte         op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    cur = 0;
    fd  = $fopen("dv/analog_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the vector file dv/analog_vectors.txt");
      total_errs++;
      return;
    end
    while (!timed_out && $fgets(line, fd) > 0)
    begin
      if ($sscanf(line, "%c", op) != 1 || op == "#" || op == "\n" || op == " ")
        continue;  // Comment or blank
      void'($sscanf(line, "%c %h %h %h %h", op, a, b, c, d));
      case (op)
        "T":
        begin
          if (cur != 0)
            end_test(cur);
          cur = a;
        end
        "W": write_reg(a[15:0], b);
        "R": read_check(a[15:0], b, c[0]);
        "S": apply_sample(a[15:0], b[15:0], c[13:0], d[13:0]);
        "D": check_dac({b[13:0], a[13:0]});
        "L":
        begin
          if (led !== a[7:0])
            flag_error($sformatf("led_o is %h, expected %h", led, a[7:0]));
        end
        default:
        begin
          $display("Unknown operation %c in the vector file", op);
          test_errs++;
        end
      endcase
    end
    if (cur != 0)
      end_test(cur);
    $fclose(fd);
  endtask

  task automatic random_stream();
    logic [31:0] bits;
    int          gain  [analog_pkg::N_CH];
    int          level [analog_pkg::N_CH];
    int          smp;
    int          pos_sat;
    int          neg_sat;
    logic [analog_pkg::N_CH-1:0][analog_pkg::SMP_W-1:0] exp;
    logic [analog_pkg::N_CH-1:0][analog_pkg::SMP_W-1:0] exp_q [$];
    pos_sat = 0;
    neg_sat = 0;
    for (int r = 0; r < 4 && !timed_out; r++)
    begin
      for (int ch = 0; ch < analog_pkg::N_CH; ch++)
      begin
        take_bits(16, bits);
        gain[ch] = int'($signed(bits[15:0]));  // Full Q3.12 range
        take_bits(14, bits);
        level[ch] = int'($signed(bits[13:0]));
        write_reg(ctrl_addr(ch, analog_pkg::OFS_CH_GAIN), 32'(gain[ch]));
        write_reg(ctrl_addr(ch, analog_pkg::OFS_CH_LEVEL), 32'(level[ch]));
      end
      exp_q.delete();
      for (int i = 0; i < STREAM_LEN + FILL && !timed_out; i++)
      begin
        @(posedge adc_clk);
        for (int ch = 0; ch < analog_pkg::N_CH; ch++)
        begin
          take_bits(16, bits);
          adc_dat[ch] <= bits[15:0];
          smp = mix_smp(raw_to_smp(bits[15:0]), gain[ch], level[ch]);
          // Only words that reach a check count
          if (i < STREAM_LEN && smp == SMP_MAX)
            pos_sat++;
          if (i < STREAM_LEN && smp == SMP_MIN)
            neg_sat++;
          exp[ch] = smp_to_code(smp);
        end
        exp_q.push_back(exp);
        @(negedge adc_clk);
        if (i >= FILL)
          check_dac(exp_q.pop_front());  // Word driven 3 edges ago
      end
    end
    if (!timed_out && (pos_sat == 0 || neg_sat == 0))
    begin
      $display("Random stream never saturated at both ends (%0d high, %0d low)",
               pos_sat, neg_sat);
      test_errs++;
    end
  endtask

  task automatic loopback_run();
    int gain  [analog_pkg::N_CH];
    int level [analog_pkg::N_CH];
    int m     [analog_pkg::N_CH];  // Stage 1 register
    int d     [analog_pkg::N_CH];  // Stage 2 register
    int m_next;
    logic [analog_pkg::N_CH-1:0][analog_pkg::SMP_W-1:0] exp;
    gain  = '{4096, 0};
    level = '{1000, -500};
    for (int ch = 0; ch < analog_pkg::N_CH; ch++)
    begin
      write_reg(ctrl_addr(ch, analog_pkg::OFS_CH_GAIN), 32'(gain[ch]));
      write_reg(ctrl_addr(ch, analog_pkg::OFS_CH_LEVEL), 32'(level[ch]));
    end
    @(posedge adc_clk);
    adc_dat <= {analog_pkg::N_CH{16'h7ffc}};  // Zero sample
    repeat (FILL + 1) @(posedge adc_clk);
    @(negedge adc_clk);
    for (int ch = 0; ch < analog_pkg::N_CH; ch++)
    begin
      m[ch]   = 0;
      d[ch]   = mix_smp(0, gain[ch], level[ch]);  // Settled on the zero input
      exp[ch] = smp_to_code(d[ch]);
    end
    check_dac(exp);
    write_reg({sys_bus_pkg::REGION_HK, analog_pkg::OFS_HK_LOOP}, 32'd1);
    // Loop bit live from here with the state as above
    for (int k = 0; k < 24 && !timed_out; k++)
    begin
      @(posedge adc_clk);
      for (int ch = 0; ch < analog_pkg::N_CH; ch++)
      begin
        m_next  = (d[ch] * gain[ch]) >>> analog_pkg::GAIN_FRAC;
        d[ch]   = sat14(m[ch] + level[ch]);
        m[ch]   = m_next;
        exp[ch] = smp_to_code(d[ch]);
      end
      @(negedge adc_clk);
      check_dac(exp);
    end
    if (!timed_out && d[0] != SMP_MAX)
    begin
      $display("Loopback on channel 0 never reached +8191");
      test_errs++;
    end
    write_reg({sys_bus_pkg::REGION_HK, analog_pkg::OFS_HK_LOOP}, 32'd0);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    rst_n   <= 1'b0;
    sys_req <= '0;
    adc_dat <= {analog_pkg::N_CH{16'h7ffc}};
    repeat (2) @(posedge adc_clk);  // Two reset cycles
    rst_n <= 1'b1;
    @(negedge adc_clk);
    run_vectors();                  // Tests 1 to 3
    if (!timed_out)
    begin
      random_stream();
      end_test(4);
    end
    if (!timed_out)
    begin
      loopback_run();
      end_test(5);
    end
    $display("tests: %0d ok, %0d with errors, %0d errors in total",
             tests_ok, tests_bad, total_errs);
    if (total_errs == 0 && tests_bad == 0 && !timed_out)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: verilog/adc_frontend.sv
`timescale 1ns/100ps

module adc_frontend (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  input  logic [analog_pkg::N_CH-1:0][analog_pkg::ADC_RAW_W-1:0] adc_dat_i,  // Raw pins
  input  logic                    digital_loop_i,
  input  analog_pkg::sample_arr_t dac_smp_i,  // Saturated mixer output
  output analog_pkg::sample_arr_t smp_o       // Two's complement samples
);

  // Upper 14 bits of each raw word
  logic [analog_pkg::N_CH-1:0][analog_pkg::SMP_W-1:0] adc_raw;

  ////////////////////////////////////////
  // Input register
  ////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      adc_raw <= '0;
    else
      for (int i = 0; i < analog_pkg::N_CH; i++)
        adc_raw[i] <= adc_dat_i[i][analog_pkg::ADC_RAW_W-1 -: analog_pkg::SMP_W];  // Drop LSBs
  end

  // Format conversion and loopback select
  always_comb
  begin
    for (int i = 0; i < analog_pkg::N_CH; i++)
    begin
      if (digital_loop_i)
        smp_o[i] = dac_smp_i[i];
      else
        smp_o[i] = analog_pkg::flip_slope(adc_raw[i]);  // Neg slope to signed
    end
  end

endmodule

// File: verilog/analog_pkg.sv
package analog_pkg;

  ////////////////////////////////////////
  // Sample formats
  ////////////////////////////////////////

  localparam int N_CH      = 2;
  localparam int CH_IDX_W  = $clog2(N_CH);
  localparam int ADC_RAW_W = 16;  // Two reserved LSBs
  localparam int SMP_W     = 14;

  typedef logic signed [SMP_W-1:0] sample_t;
  typedef sample_t [N_CH-1:0] sample_arr_t;

  // Gain in Q3.12, 4096 is unity
  localparam int GAIN_W    = 16;
  localparam int GAIN_FRAC = 12;
  localparam int PROD_W    = SMP_W + GAIN_W;     // Full product
  localparam int MUL_W     = PROD_W - GAIN_FRAC; // Product after scaling
  localparam int SUM_W     = MUL_W + 1;          // Product plus level

  typedef logic signed [GAIN_W-1:0] gain_t;

  typedef struct packed {
    sample_t level;  // Set-point
    gain_t   gain;
  } ch_cfg_t;

  typedef ch_cfg_t [N_CH-1:0] ch_cfg_arr_t;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  localparam logic [31:0] HK_ID = 32'h414e_0001;

  localparam logic [sys_bus_pkg::OFS_W-1:0] OFS_HK_ID    = 'h00;
  localparam logic [sys_bus_pkg::OFS_W-1:0] OFS_HK_LOOP  = 'h04;
  localparam logic [sys_bus_pkg::OFS_W-1:0] OFS_HK_LED   = 'h08;
  localparam logic [sys_bus_pkg::OFS_W-1:0] OFS_CH_LEVEL = 'h00;  // Within a channel
  localparam logic [sys_bus_pkg::OFS_W-1:0] OFS_CH_GAIN  = 'h04;
  localparam logic [sys_bus_pkg::OFS_W-1:0] CH_STRIDE    = 'h10;  // Channel spacing

  // Negative slope offset binary <-> two's complement, same both ways
  function automatic logic [SMP_W-1:0] flip_slope(input logic [SMP_W-1:0] code);
    return {code[SMP_W-1], ~code[SMP_W-2:0]};
  endfunction

endpackage

// File: verilog/analog_top.sv
`timescale 1ns/100ps

module analog_top (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  sys_bus_pkg::sys_req_t sys_req_i,
  output sys_bus_pkg::sys_rsp_t sys_rsp_o,
  input  logic [analog_pkg::N_CH-1:0][analog_pkg::ADC_RAW_W-1:0] adc_dat_i,
  output logic [analog_pkg::N_CH-1:0][analog_pkg::SMP_W-1:0]     dac_dat_o,  // Parallel port
  output logic [7:0]            led_o
);

  sys_bus_pkg::sys_req_t   hk_req, ctrl_req;
  sys_bus_pkg::sys_rsp_t   hk_rsp, ctrl_rsp;
  logic                    digital_loop;
  analog_pkg::ch_cfg_arr_t ch_cfg;
  analog_pkg::sample_arr_t adc_smp;  // After conversion or loopback
  analog_pkg::sample_arr_t dac_smp;  // Mixer output fed back

  ////////////////////////////////////////
  // Register bus
  ////////////////////////////////////////

  sys_bus_decoder i_sys_bus_decoder (
    .adc_clk    (adc_clk  ),
    .rst_n_i    (rst_n_i  ),
    .req_i      (sys_req_i),
    .hk_req_o   (hk_req   ),
    .ctrl_req_o (ctrl_req ),
    .hk_rsp_i   (hk_rsp   ),
    .ctrl_rsp_i (ctrl_rsp ),
    .rsp_o      (sys_rsp_o)
  );

  hk_regs i_hk_regs (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .req_i          (hk_req      ),
    .rsp_o          (hk_rsp      ),
    .digital_loop_o (digital_loop),
    .led_o          (led_o       )
  );

  ////////////////////////////////////////
  // Data path
  ////////////////////////////////////////

  adc_frontend i_adc_frontend (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .adc_dat_i      (adc_dat_i   ),
    .digital_loop_i (digital_loop),
    .dac_smp_i      (dac_smp     ),
    .smp_o          (adc_smp     )
  );

  ctrl_regs i_ctrl_regs (
    .adc_clk  (adc_clk ),
    .rst_n_i  (rst_n_i ),
    .req_i    (ctrl_req),
    .rsp_o    (ctrl_rsp),
    .ch_cfg_o (ch_cfg  )
  );

  feedback_mixer i_feedback_mixer (
    .adc_clk   (adc_clk  ),
    .rst_n_i   (rst_n_i  ),
    .smp_i     (adc_smp  ),
    .ch_cfg_i  (ch_cfg   ),
    .dac_smp_o (dac_smp  ),
    .dac_dat_o (dac_dat_o)
  );

endmodule

// File: verilog/ctrl_regs.sv
`timescale 1ns/100ps

module ctrl_regs (
  input  logic                   adc_clk,
  input  logic                   rst_n_i,
  input  sys_bus_pkg::sys_req_t  req_i,
  output sys_bus_pkg::sys_rsp_t  rsp_o,
  output analog_pkg::ch_cfg_arr_t ch_cfg_o  // Level and gain per channel
);

  localparam int LVL_EXT  = sys_bus_pkg::DATA_W - analog_pkg::SMP_W;
  localparam int GAIN_EXT = sys_bus_pkg::DATA_W - analog_pkg::GAIN_W;

  logic [sys_bus_pkg::OFS_W-1:0]  ofs;
  logic [sys_bus_pkg::OFS_W-1:0]  ch_num;   // addr[11:4]
  logic [sys_bus_pkg::OFS_W-1:0]  field;    // addr[3:0]
  logic [analog_pkg::CH_IDX_W-1:0] ch_idx;
  analog_pkg::ch_cfg_t            ch_cfg;   // Addressed channel
  logic [sys_bus_pkg::DATA_W-1:0] rdata;
  logic hit;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign ofs    = req_i.addr[sys_bus_pkg::OFS_W-1:0];
  assign ch_num = ofs / analog_pkg::CH_STRIDE;
  assign field  = ofs % analog_pkg::CH_STRIDE;
  assign ch_idx = ch_num[analog_pkg::CH_IDX_W-1:0];

  always_comb
  begin
    ch_cfg = ch_cfg_o[ch_idx];
    hit    = (ch_num < analog_pkg::N_CH);  // Channel must exist
    rdata  = '0;
    case (field)
      analog_pkg::OFS_CH_LEVEL: rdata = {{LVL_EXT{ch_cfg.level[analog_pkg::SMP_W-1]}},
                                         ch_cfg.level};
      analog_pkg::OFS_CH_GAIN:  rdata = {{GAIN_EXT{ch_cfg.gain[analog_pkg::GAIN_W-1]}},
                                         ch_cfg.gain};
      default:                  hit = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ch_cfg_o  <= '0;
      rsp_o.ack <= 1'b0;
      rsp_o.err <= 1'b0;
    end
    else
    begin
      if (req_i.wen && hit)
      begin
        if (field == analog_pkg::OFS_CH_LEVEL)
          ch_cfg_o[ch_idx].level <= req_i.wdata[analog_pkg::SMP_W-1:0];  // Low bits only
        else
          ch_cfg_o[ch_idx].gain <= req_i.wdata[analog_pkg::GAIN_W-1:0];
      end
      rsp_o.ack <= req_i.wen | req_i.ren;
      rsp_o.err <= (req_i.wen | req_i.ren) & ~hit;
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (req_i.ren)
      rsp_o.rdata <= rdata;  // Sign-extended
  end

endmodule

// File: verilog/feedback_mixer.sv
`timescale 1ns/100ps

module feedback_mixer (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  input  analog_pkg::sample_arr_t smp_i,
  input  analog_pkg::ch_cfg_arr_t ch_cfg_i,
  output analog_pkg::sample_arr_t dac_smp_o,  // Saturated, signed
  output logic [analog_pkg::N_CH-1:0][analog_pkg::SMP_W-1:0] dac_dat_o  // DAC code
);

  logic signed [analog_pkg::PROD_W-1:0] prod  [analog_pkg::N_CH];
  logic signed [analog_pkg::MUL_W-1:0]  mul_q [analog_pkg::N_CH];  // Stage 1
  logic signed [analog_pkg::SUM_W-1:0]  sum   [analog_pkg::N_CH];
  analog_pkg::sample_t                  sat   [analog_pkg::N_CH];

  ////////////////////////////////////////
  // Stage 1, gain
  ////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < analog_pkg::N_CH; i++)
      prod[i] = smp_i[i] * ch_cfg_i[i].gain;  // Full signed product
  end

  always_ff @(posedge adc_clk)
  begin
    for (int i = 0; i < analog_pkg::N_CH; i++)
    begin
      if (!rst_n_i)
        mul_q[i] <= '0;
      else
        mul_q[i] <= prod[i][analog_pkg::PROD_W-1:analog_pkg::GAIN_FRAC];  // Same as >>> 12
    end
  end

  ////////////////////////////////////////
  // Stage 2, level and saturation
  ////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < analog_pkg::N_CH; i++)
    begin
      sum[i] = mul_q[i] + ch_cfg_i[i].level;
      // Fits when all bits above the sample sign agree with it
      if (&sum[i][analog_pkg::SUM_W-1:analog_pkg::SMP_W-1] ||
          ~|sum[i][analog_pkg::SUM_W-1:analog_pkg::SMP_W-1])
        sat[i] = sum[i][analog_pkg::SMP_W-1:0];
      else
        sat[i] = {sum[i][analog_pkg::SUM_W-1],
                  {(analog_pkg::SMP_W-1){~sum[i][analog_pkg::SUM_W-1]}}};  // +8191 or -8192
    end
  end

  always_ff @(posedge adc_clk)
  begin
    for (int i = 0; i < analog_pkg::N_CH; i++)
    begin
      if (!rst_n_i)
      begin
        dac_smp_o[i] <= '0;
        dac_dat_o[i] <= analog_pkg::flip_slope('0);  // Mid-scale code 14'h1fff
      end
      else
      begin
        dac_smp_o[i] <= sat[i];
        dac_dat_o[i] <= analog_pkg::flip_slope(sat[i]);  // Back to neg slope
      end
    end
  end

endmodule

// File: verilog/hk_regs.sv
`timescale 1ns/100ps

module hk_regs (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  sys_bus_pkg::sys_req_t req_i,
  output sys_bus_pkg::sys_rsp_t rsp_o,
  output logic                  digital_loop_o,  // DAC values back into ADC path
  output logic [7:0]            led_o
);

  logic [sys_bus_pkg::OFS_W-1:0]  ofs;
  logic [sys_bus_pkg::DATA_W-1:0] rdata;
  logic hit;  // Offset is mapped

  assign ofs = req_i.addr[sys_bus_pkg::OFS_W-1:0];

  // Read mux and address check
  always_comb
  begin
    hit   = 1'b1;
    rdata = '0;
    case (ofs)
      analog_pkg::OFS_HK_ID:   rdata = analog_pkg::HK_ID;
      analog_pkg::OFS_HK_LOOP: rdata[0] = digital_loop_o;
      analog_pkg::OFS_HK_LED:  rdata[7:0] = led_o;
      default:                 hit = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      rsp_o.ack      <= 1'b0;
      rsp_o.err      <= 1'b0;
    end
    else
    begin
      if (req_i.wen && ofs == analog_pkg::OFS_HK_LOOP)
        digital_loop_o <= req_i.wdata[0];
      if (req_i.wen && ofs == analog_pkg::OFS_HK_LED)
        led_o <= req_i.wdata[7:0];
      rsp_o.ack <= req_i.wen | req_i.ren;              // One cycle after strobe
      rsp_o.err <= (req_i.wen | req_i.ren) & ~hit;     // ID writes are dropped quietly
    end
  end

  // Read data
  always_ff @(posedge adc_clk)
  begin
    if (req_i.ren)
      rsp_o.rdata <= rdata;
  end

endmodule

// File: verilog/sys_bus_decoder.sv
`timescale 1ns/100ps

module sys_bus_decoder (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  sys_bus_pkg::sys_req_t req_i,       // From bus master
  output sys_bus_pkg::sys_req_t hk_req_o,
  output sys_bus_pkg::sys_req_t ctrl_req_o,
  input  sys_bus_pkg::sys_rsp_t hk_rsp_i,
  input  sys_bus_pkg::sys_rsp_t ctrl_rsp_i,
  output sys_bus_pkg::sys_rsp_t rsp_o        // Back to master
);

  logic [sys_bus_pkg::REGION_W-1:0] region;
  logic [sys_bus_pkg::REGION_W-1:0] region_q;  // Region of last request
  logic strobe;
  logic hk_sel;
  logic ctrl_sel;
  logic miss_q;  // Unmapped region pending

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  assign region   = req_i.addr[sys_bus_pkg::ADDR_W-1 -: sys_bus_pkg::REGION_W];
  assign strobe   = req_i.wen | req_i.ren;
  assign hk_sel   = (region == sys_bus_pkg::REGION_HK);
  assign ctrl_sel = (region == sys_bus_pkg::REGION_CTRL);

  // Address and data go everywhere, strobes only to the selected block
  always_comb
  begin
    hk_req_o       = req_i;
    hk_req_o.wen   = req_i.wen & hk_sel;
    hk_req_o.ren   = req_i.ren & hk_sel;
    ctrl_req_o     = req_i;
    ctrl_req_o.wen = req_i.wen & ctrl_sel;
    ctrl_req_o.ren = req_i.ren & ctrl_sel;
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      region_q <= sys_bus_pkg::REGION_HK;
      miss_q   <= 1'b0;
    end
    else
    begin
      if (strobe)
        region_q <= region;  // Held until next request
      miss_q <= strobe & ~hk_sel & ~ctrl_sel;
    end
  end

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////

  always_comb
  begin
    case (region_q)
      sys_bus_pkg::REGION_HK:   rsp_o = hk_rsp_i;
      sys_bus_pkg::REGION_CTRL: rsp_o = ctrl_rsp_i;
      default:                  rsp_o = '{rdata: '0, ack: miss_q, err: miss_q};
    endcase
  end

endmodule

// File: verilog/sys_bus_pkg.sv
package sys_bus_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////

  localparam int ADDR_W   = 16;  // Byte address
  localparam int DATA_W   = 32;
  localparam int REGION_W = 4;   // Region number in addr[15:12]
  localparam int OFS_W    = ADDR_W - REGION_W;  // Offset inside a region

  // Region numbers
  localparam logic [REGION_W-1:0] REGION_HK   = 4'd0;  // Housekeeping
  localparam logic [REGION_W-1:0] REGION_CTRL = 4'd1;  // Feedback control

  ////////////////////////////////////////
  // Request and response words
  ////////////////////////////////////////

  // One cycle strobe, wen or ren
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              wen;
    logic              ren;
  } sys_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;  // Valid with ack
    logic              ack;
    logic              err;
  } sys_rsp_t;

endpackage
